/* build.f */
+incdir+.
rv_pkg.sv
register_file.sv
rv_decoder.sv
rv_alu.sv
exec_control.sv
rv_exec_unit.sv
rv_exec_checker.sv
rv_exec_properties.sv
tb_rv_exec_unit.sv

/* tb_rv_exec_unit.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module tb_rv_exec_unit import rv_pkg::*; ();

  localparam int NUM_ISSUE      = 400;
  localparam int RESET_CYCLES   = 10;
  localparam int TIMEOUT_CYCLES = 3 * NUM_ISSUE + RESET_CYCLES + 100;

  logic                   clk;
  logic                   arst_n;
  logic                   instr_valid;
  logic [`RV_XLEN-1:0]    instr;
  logic                   busy;
  logic                   done;
  logic                   illegal;
  logic [`RV_RADDR_W-1:0] rd_addr;
  logic [`RV_XLEN-1:0]    rd_data;
  logic [15:0]            lfsr;
  logic                   chk_idle;
  int                     errors;
  int                     completed;
  int                     issued;
  int                     cycle_count;

  always #2 clk = ~clk;  // 4 ns period

  rv_exec_unit DUT (
    .i_clk         (clk),
    .i_arst_n      (arst_n),
    .i_instr_valid (instr_valid),
    .i_instr       (instr),
    .o_busy        (busy),
    .o_done        (done),
    .o_illegal     (illegal),
    .o_rd_addr     (rd_addr),
    .o_rd_data     (rd_data)
  );

  rv_exec_checker u_checker (
    .i_clk         (clk),
    .i_arst_n      (arst_n),
    .i_instr_valid (instr_valid),
    .i_instr       (instr),
    .i_busy        (busy),
    .i_done        (done),
    .i_illegal     (illegal),
    .i_rd_addr     (rd_addr),
    .i_rd_data     (rd_data),
    .o_errors      (errors),
    .o_completed   (completed),
    .o_idle        (chk_idle)
  );

  // Fibonacci LFSR with taps 16, 14, 13 and 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic pick_reg(output logic [4:0] r);
    logic [31:0] b;
    rand_bits(2, b);
    if (b[1:0] != 2'b11) rand_bits(2, b);  // Mostly x0..x3 so results get reused
    else rand_bits(5, b);
    r = b[4:0];
  endtask

  task automatic make_instr(output logic [31:0] ins);
    logic [31:0] cls;
    logic [31:0] f3;
    logic [31:0] imm;
    logic [31:0] pick;
    logic [31:0] extra;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [6:0]  f7;
    rand_bits(3, cls);
    rand_bits(3, f3);
    rand_bits(12, imm);
    rand_bits(2, pick);
    rand_bits(8, extra);
    pick_reg(rd);
    pick_reg(rs1);
    pick_reg(rs2);
    f7 = pick[0] ? 7'b0100000 : 7'b0000000;
    case (cls[2:0])
      3'd0, 3'd1, 3'd2: begin
        if (!(f3[2:0] == 3'b000 || f3[2:0] == 3'b101)) f7 = 7'b0000000;
        ins = {f7, rs2, rs1, f3[2:0], rd, OPC_OP};
      end
      3'd3, 3'd4, 3'd5: begin
        if (f3[2:0] == 3'b001) imm[11:5] = 7'b0000000;
        if (f3[2:0] == 3'b101) imm[11:5] = f7;  // SRLI or SRAI
        ins = {imm[11:0], rs1, f3[2:0], rd, OPC_OP_IMM};
      end
      3'd6: ins = {extra[7:0], imm[11:0], rd, OPC_LUI};
      default: begin
        // Reserved funct7, raw shift immediate, or an arbitrary opcode
        if (pick[1:0] == 2'd0) ins = {extra[6:0], rs2, rs1, f3[2:0], rd, OPC_OP};
        else if (pick[1:0] == 2'd1) ins = {imm[11:0], rs1, f3[2:0], rd, OPC_OP_IMM};
        else ins = {imm[11:0], rs1, f3[2:0], rd, extra[6:0]};
      end
    endcase
  endtask

  initial begin
    logic [31:0] bits;
    logic [31:0] word;
    clk         = 1'b0;
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    lfsr        = 16'd13;
    issued      = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    while (issued < NUM_ISSUE) begin
      @(negedge clk);
      rand_bits(2, bits);
      make_instr(word);
      instr       = word;
      instr_valid = (bits[1:0] != 2'b00);  // High three times in four, so some land while busy
      if (instr_valid) issued++;
    end
    @(negedge clk);
    instr_valid = 1'b0;
    while (!chk_idle) @(negedge clk);
    $display("Run finished: %0d instructions completed, %0d errors", completed, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Run stopped: %0d instructions completed, %0d errors", completed, errors);
      $display("Checks failed");
      $finish;
    end
  end

endmodule

/* rv_exec_properties.sv */
`timescale 1ns/1ps

module rv_exec_properties (
  input logic i_clk,
  input logic i_arst_n,
  input logic i_instr_valid,
  input logic i_busy,
  input logic i_done,
  input logic i_illegal
);

  a_pulse_exclusive: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    !(i_done && i_illegal)) else $error("o_done and o_illegal high in the same cycle");

  a_done_single: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_done |=> !i_done) else $error("o_done held for more than one cycle");

  a_illegal_single: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_illegal |=> !i_illegal) else $error("o_illegal held for more than one cycle");

  // An idle unit takes the strobe and is busy one edge later
  a_busy_follows: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (i_instr_valid && !i_busy) |=> i_busy) else $error("o_busy did not follow an accepted strobe");

endmodule

bind rv_exec_unit rv_exec_properties u_properties (
  .i_clk         (i_clk),
  .i_arst_n      (i_arst_n),
  .i_instr_valid (i_instr_valid),
  .i_busy        (o_busy),
  .i_done        (o_done),
  .i_illegal     (o_illegal)
);

/* rv_exec_checker.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_exec_checker import rv_pkg::*; (
  input  logic                   i_clk,
  input  logic                   i_arst_n,
  input  logic                   i_instr_valid,
  input  logic [`RV_XLEN-1:0]    i_instr,
  input  logic                   i_busy,
  input  logic                   i_done,
  input  logic                   i_illegal,
  input  logic [`RV_RADDR_W-1:0] i_rd_addr,
  input  logic [`RV_XLEN-1:0]    i_rd_data,
  output int                     o_errors,
  output int                     o_completed,
  output logic                   o_idle
);

  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB and SRA/SRAI

  logic [`RV_XLEN-1:0]    model [0:`RV_NREGS-1];
  logic [1:0]             pend_valid;  // Bit 0 accepted one edge ago, bit 1 two edges ago
  logic [1:0]             pend_bad;
  logic [`RV_RADDR_W-1:0] pend_rd [0:1];
  logic [`RV_XLEN-1:0]    pend_data [0:1];
  logic [`RV_RADDR_W-1:0] last_rd_addr;
  logic [`RV_XLEN-1:0]    last_rd_data;
  logic [`RV_XLEN:0]      pred;
  logic                   accept;

  assign o_idle = (pend_valid == 2'b00);

  // Returns the illegal flag above the expected result
  function automatic logic [`RV_XLEN:0] predict(input logic [31:0] ins, input logic [31:0] a,
                                                input logic [31:0] r2);
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] b;
    logic [31:0] res;
    logic        alt;
    logic        bad;
    f3  = ins[`RV_F3_MSB:`RV_F3_LSB];
    f7  = ins[`RV_F7_MSB:`RV_F7_LSB];
    b   = r2;
    alt = (f7 == F7_ALT);
    bad = 1'b0;
    case (ins[`RV_OPC_MSB:`RV_OPC_LSB])
      OPC_OP: bad = !(f7 == F7_BASE || (alt && (f3 == F3_ADD || f3 == F3_SR)));
      OPC_OP_IMM: begin
        b   = {{20{ins[31]}}, ins[31:20]};  // Shift amount sits in the low five bits
        alt = alt && (f3 == F3_SR);
        if (f3 == F3_SLL || f3 == F3_SR) bad = !(f7 == F7_BASE || alt);
      end
      OPC_LUI: return {1'b0, ins[31:12], 12'h000};
      default: bad = 1'b1;
    endcase
    case (f3)
      F3_ADD:  res = alt ? a - b : a + b;
      F3_SLL:  res = a << b[4:0];
      F3_SLT:  res = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};  // Negative one is less
      F3_SLTU: res = {31'b0, a < b};
      F3_XOR:  res = a ^ b;
      F3_SR:   res = (a >> b[4:0]) | ((alt && a[31]) ? ~(32'hFFFF_FFFF >> b[4:0]) : '0);
      F3_OR:   res = a | b;
      default: res = a & b;
    endcase
    return {bad, res};
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp) begin
      o_errors++;
      $display("ERROR %0t: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic report_failure(input string what);
    o_errors++;
    $display("%0t: %s", $time, what);
  endtask

  always @(posedge i_clk) begin
    if (!i_arst_n) begin
      for (int i = 0; i < `RV_NREGS; i++) model[i] = '0;
      pend_valid   = '0;
      last_rd_addr = '0;
      last_rd_data = '0;
    end else begin
      check_value("o_busy", pend_valid[0], i_busy);
      if (pend_valid[1] && !pend_bad[1]) begin
        last_rd_addr = pend_rd[1];
        last_rd_data = pend_data[1];
        o_completed++;
      end
      if (i_done !== (pend_valid[1] && !pend_bad[1]))
        report_failure(i_done ? "o_done pulsed with no legal instruction due"
                              : "o_done missing two edges after a legal instruction");
      if (i_illegal !== (pend_valid[1] && pend_bad[1]))
        report_failure(i_illegal ? "o_illegal pulsed with no illegal instruction due"
                                 : "o_illegal missing two edges after an illegal instruction");
      check_value("o_rd_addr", last_rd_addr, i_rd_addr);
      check_value("o_rd_data", last_rd_data, i_rd_data);
      accept       = i_instr_valid && !pend_valid[0];  // Strobes while busy leave no trace
      pend_valid   = {pend_valid[0], accept};
      pend_bad[1]  = pend_bad[0];
      pend_rd[1]   = pend_rd[0];
      pend_data[1] = pend_data[0];
      if (accept) begin
        pred         = predict(i_instr, model[i_instr[`RV_RS1_MSB:`RV_RS1_LSB]],
                               model[i_instr[`RV_RS2_MSB:`RV_RS2_LSB]]);
        pend_bad[0]  = pred[`RV_XLEN];
        pend_rd[0]   = i_instr[`RV_RD_MSB:`RV_RD_LSB];
        pend_data[0] = pred[`RV_XLEN-1:0];
        if (!pred[`RV_XLEN]) model[pend_rd[0]] = pred[`RV_XLEN-1:0];
        model[0] = '0;  // x0 stays zero whatever was written
      end
    end
  end

endmodule

/* rv_exec_unit.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_exec_unit import rv_pkg::*; (
  input  logic                   i_clk,
  input  logic                   i_arst_n,
  input  logic                   i_instr_valid,
  input  logic [`RV_XLEN-1:0]    i_instr,
  output logic                   o_busy,
  output logic                   o_done,
  output logic                   o_illegal,
  output logic [`RV_RADDR_W-1:0] o_rd_addr,
  output logic [`RV_XLEN-1:0]    o_rd_data
);

  logic [`RV_XLEN-1:0] ir;
  logic                load;
  alu_op_e             alu_op;
  logic                b_sel;
  logic [`RV_XLEN-1:0] imm;
  logic                illegal;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic [`RV_XLEN-1:0] operand_b;
  logic [`RV_XLEN-1:0] result;

  assign operand_b = b_sel ? imm : rs2_data;  // Immediate forms take B from the decoder

  exec_control u_control (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_instr_valid (i_instr_valid),
    .i_instr       (i_instr),
    .i_illegal     (illegal),
    .i_result      (result),
    .o_ir          (ir),
    .o_load        (load),
    .o_busy        (o_busy),
    .o_done        (o_done),
    .o_illegal     (o_illegal),
    .o_rd_addr     (o_rd_addr),
    .o_rd_data     (o_rd_data)
  );

  rv_decoder u_decoder (
    .i_ir      (ir),
    .o_alu_op  (alu_op),
    .o_b_sel   (b_sel),
    .o_imm     (imm),
    .o_illegal (illegal)
  );

  register_file u_regfile (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_ir      (ir),
    .i_load    (load),
    .i_data    (result),
    .o_regout1 (rs1_data),
    .o_regout2 (rs2_data)
  );

  rv_alu u_alu (
    .i_op     (alu_op),
    .i_a      (rs1_data),
    .i_b      (operand_b),
    .o_result (result)
  );

endmodule

/* exec_control.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module exec_control import rv_pkg::*; (
  input  logic                   i_clk,
  input  logic                   i_arst_n,
  input  logic                   i_instr_valid,
  input  logic [`RV_XLEN-1:0]    i_instr,
  input  logic                   i_illegal,
  input  logic [`RV_XLEN-1:0]    i_result,
  output logic [`RV_XLEN-1:0]    o_ir,
  output logic                   o_load,
  output logic                   o_busy,
  output logic                   o_done,
  output logic                   o_illegal,
  output logic [`RV_RADDR_W-1:0] o_rd_addr,
  output logic [`RV_XLEN-1:0]    o_rd_data
);

  exec_state_e state;
  logic        accept;

  assign accept = i_instr_valid && (state == ST_IDLE);  // Strobes while busy are dropped
  assign o_busy = (state == ST_EXEC);
  assign o_load = (state == ST_EXEC) && !i_illegal;     // Write only legal instructions

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: if (accept) state <= ST_EXEC;
        ST_EXEC: state <= ST_IDLE;  // Single execute cycle
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_ir <= i_instr;  // Held for decode, register reads and the write selector
    end
  end

  // Completion pulses and the reported write
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_done    <= 1'b0;
      o_illegal <= 1'b0;
      o_rd_addr <= '0;
      o_rd_data <= '0;
    end else begin
      o_done    <= o_load;
      o_illegal <= o_busy && i_illegal;
      if (o_load) begin
        o_rd_addr <= o_ir[`RV_RD_MSB:`RV_RD_LSB];
        o_rd_data <= i_result;  // Shown even when rd is x0
      end
    end
  end

endmodule

/* rv_alu.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_alu import rv_pkg::*; (
  input  alu_op_e             i_op,
  input  logic [`RV_XLEN-1:0] i_a,
  input  logic [`RV_XLEN-1:0] i_b,
  output logic [`RV_XLEN-1:0] o_result
);

  logic [4:0]          shamt;
  logic                lt_signed;
  logic                lt_unsigned;
  logic [`RV_XLEN-1:0] sra_res;

  assign shamt       = i_b[4:0];  // Only the low five bits count in RV32I
  assign lt_signed   = $signed(i_a) < $signed(i_b);
  assign lt_unsigned = i_a < i_b;
  assign sra_res     = $unsigned($signed(i_a) >>> shamt);

  always_comb begin
    case (i_op)
      ALU_ADD:    o_result = i_a + i_b;
      ALU_SUB:    o_result = i_a - i_b;
      ALU_SLL:    o_result = i_a << shamt;
      ALU_SLT:    o_result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU:   o_result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
      ALU_XOR:    o_result = i_a ^ i_b;
      ALU_SRL:    o_result = i_a >> shamt;
      ALU_SRA:    o_result = sra_res;  // Fills with the sign bit of A
      ALU_OR:     o_result = i_a | i_b;
      ALU_AND:    o_result = i_a & i_b;
      ALU_PASS_B: o_result = i_b;
      default:    o_result = '0;
    endcase
  end

endmodule

/* rv_decoder.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_decoder import rv_pkg::*; (
  input  logic [`RV_XLEN-1:0] i_ir,
  output alu_op_e             o_alu_op,
  output logic                o_b_sel,
  output logic [`RV_XLEN-1:0] o_imm,
  output logic                o_illegal
);

  rv_opcode_e          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] shamt;

  assign opcode = rv_opcode_e'(i_ir[`RV_OPC_MSB:`RV_OPC_LSB]);
  assign funct3 = i_ir[`RV_F3_MSB:`RV_F3_LSB];
  assign funct7 = i_ir[`RV_F7_MSB:`RV_F7_LSB];

  assign imm_i = {{(`RV_XLEN-12){i_ir[31]}}, i_ir[31:20]};       // Sign-extended 12 bits
  assign imm_u = {i_ir[31:12], 12'b0};                            // Upper immediate for LUI
  assign shamt = {{(`RV_XLEN-5){1'b0}}, i_ir[`RV_RS2_MSB:`RV_RS2_LSB]};

  // Operation selected by funct3 when funct7 is all zero, common to R and I forms
  function automatic alu_op_e base_op(input logic [2:0] f3);
    case (f3)
      3'b000:  base_op = ALU_ADD;
      3'b001:  base_op = ALU_SLL;
      3'b010:  base_op = ALU_SLT;
      3'b011:  base_op = ALU_SLTU;
      3'b100:  base_op = ALU_XOR;
      3'b101:  base_op = ALU_SRL;
      3'b110:  base_op = ALU_OR;
      default: base_op = ALU_AND;
    endcase
  endfunction

  always_comb begin
    o_alu_op  = ALU_ADD;
    o_b_sel   = 1'b0;
    o_imm     = '0;
    o_illegal = 1'b0;
    case (opcode)
      OPC_OP: begin
        if (funct7 == 7'b0000000) begin
          o_alu_op = base_op(funct3);
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          o_alu_op = ALU_SUB;
        end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
          o_alu_op = ALU_SRA;
        end else begin
          o_illegal = 1'b1;  // Any other funct7 is reserved
        end
      end
      OPC_OP_IMM: begin
        o_b_sel  = 1'b1;
        o_alu_op = base_op(funct3);
        o_imm    = imm_i;
        if (funct3 == 3'b001 || funct3 == 3'b101) begin
          o_imm = shamt;  // Shifts carry their amount in the rs2 field
          if (funct3 == 3'b101 && funct7 == 7'b0100000) begin
            o_alu_op = ALU_SRA;
          end else if (funct7 != 7'b0000000) begin
            o_illegal = 1'b1;
          end
        end
      end
      OPC_LUI: begin
        o_alu_op = ALU_PASS_B;
        o_b_sel  = 1'b1;
        o_imm    = imm_u;
      end
      default: o_illegal = 1'b1;  // Opcode outside the supported subset
    endcase
  end

endmodule

/* register_file.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module register_file (
  input  logic                i_clk,
  input  logic                i_arst_n,
  input  logic [`RV_XLEN-1:0] i_ir,
  input  logic                i_load,
  input  logic [`RV_XLEN-1:0] i_data,
  output logic [`RV_XLEN-1:0] o_regout1,
  output logic [`RV_XLEN-1:0] o_regout2
);

  logic [`RV_XLEN-1:0]    regs [0:`RV_NREGS-1];
  logic [`RV_RADDR_W-1:0] sel_in;
  logic [`RV_RADDR_W-1:0] sel_out1;
  logic [`RV_RADDR_W-1:0] sel_out2;

  // Selectors come straight from the instruction fields
  assign sel_in   = i_ir[`RV_RD_MSB:`RV_RD_LSB];
  assign sel_out1 = i_ir[`RV_RS1_MSB:`RV_RS1_LSB];
  assign sel_out2 = i_ir[`RV_RS2_MSB:`RV_RS2_LSB];

  // x0 is hardwired to zero on both read ports
  assign o_regout1 = (sel_out1 == '0) ? '0 : regs[sel_out1];
  assign o_regout2 = (sel_out2 == '0) ? '0 : regs[sel_out2];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;  // Whole file starts at zero
      end
    end else if (i_load && (sel_in != '0)) begin
      regs[sel_in] <= i_data;  // Writes to x0 are dropped
    end
  end

endmodule

/* rv_pkg.sv */
package rv_pkg;

  // Major opcodes handled by the execute unit
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,  // Register-register ALU
    OPC_OP_IMM = 7'b0010011,  // Register-immediate ALU
    OPC_LUI    = 7'b0110111   // Load upper immediate
  } rv_opcode_e;

  // ALU functions, one per distinct datapath behaviour
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10  // Forwards operand B, used by LUI
  } alu_op_e;

  // Control FSM states
  typedef enum logic {
    ST_IDLE = 1'b0,  // Waiting for a strobe
    ST_EXEC = 1'b1   // Instruction held in ir, result being written
  } exec_state_e;

endpackage

/* rv_defines.svh */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

`define RV_XLEN    32  // Data path width of RV32I
`define RV_NREGS   32  // Architectural integer registers x0..x31
`define RV_RADDR_W 5   // Bits needed to address one register

// Instruction field positions shared by every R, I and U format
`define RV_OPC_MSB 6
`define RV_OPC_LSB 0
`define RV_RD_MSB  11
`define RV_RD_LSB  7
`define RV_F3_MSB  14
`define RV_F3_LSB  12
`define RV_RS1_MSB 19
`define RV_RS1_LSB 15
`define RV_RS2_MSB 24
`define RV_RS2_LSB 20
`define RV_F7_MSB  31
`define RV_F7_LSB  25

`endif
